// ==== project.f ====
+incdir+include
verilog/csr_pkg.sv
verilog/csr_decode.sv
verilog/csr_store.sv
verilog/csr_exec.sv
verilog/csr_unit.sv
verif/csr_unit_tb.sv

// ==== include/csr_ref.svh ====
/*
 * CSR reference model
 * Expected rd write and new CSR value for one Zicsr instruction
 */

`ifndef CSR_REF_SVH
`define CSR_REF_SVH

// Relies on csr_pkg being imported by the including scope
function automatic void csr_ref(
    input  csr_instr_u      instr,
    input  logic [XLEN-1:0] rs1_val,
    input  logic [XLEN-1:0] old_val,
    output logic            exp_rd_wr,
    output logic [XLEN-1:0] exp_rd_val,
    output logic [XLEN-1:0] new_val
);
    logic [XLEN-1:0] zimm_val;
    logic            rs1_nz;
    logic            zimm_nz;

    zimm_val   = XLEN'(instr.i.zimm);
    rs1_nz     = (instr.r.rs1 != '0);
    zimm_nz    = (instr.i.zimm != '0);
    new_val    = old_val;
    exp_rd_val = old_val;
    exp_rd_wr  = (instr.r.rd != '0);

    // Every Zicsr code reads the old value into rd
    case (instr.r.funct3)
        F3_CSRRW:  new_val = rs1_val;
        F3_CSRRWI: new_val = zimm_val;
        F3_CSRRS: begin
            if (rs1_nz) begin
                new_val = old_val | rs1_val;
            end
        end
        F3_CSRRC: begin
            if (rs1_nz) begin
                new_val = old_val & ~rs1_val;
            end
        end
        F3_CSRRSI: begin
            if (zimm_nz) begin
                new_val = old_val | zimm_val;
            end
        end
        F3_CSRRCI: begin
            if (zimm_nz) begin
                new_val = old_val & ~zimm_val;
            end
        end
        // Unknown codes neither read nor write
        default:   exp_rd_wr = 1'b0;
    endcase
endfunction

`endif

// ==== verif/csr_unit_tb.sv ====
/*
 * CSR unit testbench
 * Random and directed Zicsr traffic checked against a shadow CSR model
 */

`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb
    import csr_pkg::*;
;

    `include "csr_ref.svh"

    localparam logic [OPCODE_W-1:0] SYSTEM_OPCODE = 7'h73;

    // Instructions issued by each phase
    localparam int INIT_INSTR  = 2 * CSR_DEPTH;
    localparam int MASK_INSTR  = 80;
    localparam int RULE_INSTR  = 8;
    localparam int RAND_INSTR  = 100;
    localparam int ALIAS_INSTR = 8;
    localparam int SRST_INSTR  = 3;
    localparam int NUM_INSTR   = INIT_INSTR + MASK_INSTR + RULE_INSTR + RAND_INSTR
                                 + ALIAS_INSTR + SRST_INSTR;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 3 + 200;

    logic                  aclk;
    logic                  aresetn;
    logic                  srst;
    logic                  valid;
    csr_instr_u            instr;
    logic [XLEN-1:0]       rs1_val;
    logic                  ready;
    logic                  rd_wr;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       rd_val;

    logic [XLEN-1:0]       shadow [CSR_DEPTH];
    logic [REG_ADDR_W-1:0] exp_addr_q [$];
    logic [XLEN-1:0]       exp_val_q [$];
    bit                    exp_chk_q [$];
    int                    errors;
    int                    pulses;
    int                    exp_pulses;
    int                    cycles;
    logic [REG_ADDR_W-1:0] got_addr_exp;
    logic [XLEN-1:0]       got_val_exp;
    bit                    got_chk;

    csr_unit csr_unit_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .srst    (srst),
        .valid   (valid),
        .instr   (instr),
        .rs1_val (rs1_val),
        .ready   (ready),
        .rd_wr   (rd_wr),
        .rd_addr (rd_addr),
        .rd_val  (rd_val)
    );

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    task automatic check_value(input string what, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    function automatic csr_instr_u make_instr(input logic [CSR_W-1:0] csr,
                                              input logic [REG_ADDR_W-1:0] src,
                                              input logic [FUNCT3_W-1:0] funct3,
                                              input logic [REG_ADDR_W-1:0] rd);
        csr_instr_u ins;
        ins.r.csr    = csr;
        ins.r.rs1    = src;
        ins.r.funct3 = funct3;
        ins.r.rd     = rd;
        ins.r.opcode = SYSTEM_OPCODE;
        return ins;
    endfunction

    // Hold valid until the transfer edge and then update the shadow model
    task automatic send(input csr_instr_u ins, input logic [XLEN-1:0] rs1,
                        input bit commit, input bit check_val);
        logic            exp_wr;
        logic [XLEN-1:0] exp_val;
        logic [XLEN-1:0] nv;
        @(negedge aclk);
        instr   = ins;
        rs1_val = rs1;
        valid   = 1'b1;
        while (!ready) @(negedge aclk);
        @(posedge aclk);
        if (commit) begin
            csr_ref(ins, rs1, shadow[ins.r.csr[CSR_ADDR_W-1:0]], exp_wr, exp_val, nv);
            shadow[ins.r.csr[CSR_ADDR_W-1:0]] = nv;
            if (exp_wr) begin
                exp_addr_q.push_back(ins.r.rd);
                exp_val_q.push_back(exp_val);
                exp_chk_q.push_back(check_val);
                exp_pulses++;
            end
        end
    endtask

    task automatic issue(input csr_instr_u ins, input logic [XLEN-1:0] rs1);
        send(ins, rs1, 1'b1, 1'b1);
    endtask

    task automatic wait_idle();
        @(negedge aclk);
        valid = 1'b0;
        while (!ready) @(negedge aclk);
    endtask

    function automatic logic [REG_ADDR_W-1:0] rand_rd_nz();
        return REG_ADDR_W'(1 + $urandom % 31);
    endfunction

    // rd_wr is a single-cycle pulse and is sampled mid-cycle
    initial begin
        forever begin
            @(negedge aclk);
            if (aresetn && rd_wr) begin
                pulses++;
                if (exp_addr_q.size() == 0) begin
                    errors++;
                    $display("Unexpected rd_wr pulse at %0t ns with no write pending", $time);
                end else begin
                    got_addr_exp = exp_addr_q.pop_front();
                    got_val_exp  = exp_val_q.pop_front();
                    got_chk      = exp_chk_q.pop_front();
                    check_value("rd_addr", XLEN'(rd_addr), XLEN'(got_addr_exp));
                    if (got_chk) begin
                        check_value("rd_val", rd_val, got_val_exp);
                    end
                end
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge aclk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [FUNCT3_W-1:0]   f3;
        logic [CSR_ADDR_W-1:0] lo;
        logic [3:0]            up1;
        logic [3:0]            up2;

        void'($urandom(32'h8a25));
        errors     = 0;
        pulses     = 0;
        exp_pulses = 0;
        aresetn    = 1'b0;
        srst       = 1'b0;
        valid      = 1'b0;
        instr      = '0;
        rs1_val    = '0;
        for (int a = 0; a < CSR_DEPTH; a++) begin
            shadow[a] = '0;
        end
        repeat (4) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        check_value("ready after reset", XLEN'(ready), 1);
        check_value("rd_val after reset", rd_val, '0);

        // First-pass old values are unknown because the store has no reset
        for (int a = 0; a < CSR_DEPTH; a++) begin
            send(make_instr(CSR_W'(a), 5'd1, F3_CSRRW, rand_rd_nz()), $urandom, 1'b1, 1'b0);
        end
        for (int a = 0; a < CSR_DEPTH; a++) begin
            issue(make_instr(CSR_W'(a), 5'd0, F3_CSRRS, rand_rd_nz()), $urandom);
        end

        // Set and clear masks with a read-back after each
        for (int n = 0; n < MASK_INSTR / 2; n++) begin
            lo = CSR_ADDR_W'($urandom);
            case ($urandom % 4)
                0:       f3 = F3_CSRRS;
                1:       f3 = F3_CSRRC;
                2:       f3 = F3_CSRRSI;
                default: f3 = F3_CSRRCI;
            endcase
            issue(make_instr(CSR_W'(lo), rand_rd_nz(), f3, rand_rd_nz()), $urandom);
            issue(make_instr(CSR_W'(lo), 5'd0, F3_CSRRS, rand_rd_nz()), '0);
        end

        // Side-effect rules
        issue(make_instr(12'd5, 5'd9, F3_CSRRW, 5'd0), $urandom);
        issue(make_instr(12'd5, 5'd0, F3_CSRRS, 5'd2), '0);
        issue(make_instr(12'd6, 5'd0, F3_CSRRSI, 5'd3), $urandom);
        issue(make_instr(12'd6, 5'd0, F3_CSRRCI, 5'd4), $urandom);
        issue(make_instr(12'd6, 5'd0, F3_CSRRS, 5'd5), '0);
        issue(make_instr(12'd7, 5'd8, 3'd0, 5'd6), $urandom);
        issue(make_instr(12'd7, 5'd8, 3'd4, 5'd7), $urandom);
        issue(make_instr(12'd7, 5'd0, F3_CSRRS, 5'd8), '0);

        // Random mix with valid held high between instructions
        for (int n = 0; n < RAND_INSTR; n++) begin
            f3 = FUNCT3_W'($urandom);
            issue(make_instr(CSR_W'(CSR_ADDR_W'($urandom)), REG_ADDR_W'($urandom), f3,
                             REG_ADDR_W'($urandom)), $urandom);
        end

        // Upper csr bits alias onto the same entry
        for (int n = 0; n < ALIAS_INSTR / 2; n++) begin
            lo  = CSR_ADDR_W'($urandom);
            up1 = 4'($urandom);
            up2 = up1 ^ 4'(1 + $urandom % 15);
            issue(make_instr({up1, lo}, 5'd1, F3_CSRRW, rand_rd_nz()), $urandom);
            issue(make_instr({up2, lo}, 5'd0, F3_CSRRS, rand_rd_nz()), '0);
        end

        // Synchronous reset while an instruction is in flight
        lo = CSR_ADDR_W'($urandom);
        issue(make_instr(CSR_W'(lo), 5'd1, F3_CSRRW, 5'd3), $urandom);
        send(make_instr(CSR_W'(lo), 5'd1, F3_CSRRW, 5'd4), $urandom, 1'b0, 1'b0);
        @(negedge aclk);
        valid = 1'b0;
        srst  = 1'b1;
        @(negedge aclk);
        srst = 1'b0;
        check_value("ready after srst", XLEN'(ready), 1);
        issue(make_instr(CSR_W'(lo), 5'd0, F3_CSRRS, 5'd5), '0);

        wait_idle();
        if (exp_addr_q.size() != 0) begin
            errors++;
            $display("Missing rd_wr pulse: %0d expected writes never arrived",
                     exp_addr_q.size());
        end
        check_value("rd_wr pulse count", XLEN'(pulses), XLEN'(exp_pulses));

        $display("Errors: %0d, rd_wr pulses seen %0d of %0d", errors, pulses, exp_pulses);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/csr_decode.sv ====
/*
 * CSR instruction decoder
 * Maps funct3 to an update kind, selects the operand and applies write rules
 */

`timescale 1ns/1ps
`default_nettype none

module csr_decode
    import csr_pkg::*;
(
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  srst,
    input  logic                  accept,
    input  csr_instr_u            instr,
    input  logic [XLEN-1:0]       rs1_val,
    output logic                  rd_en,
    output logic [CSR_ADDR_W-1:0] rd_addr_req,
    output logic [CSR_ADDR_W-1:0] csr_addr,
    output logic [XLEN-1:0]       operand,
    output csr_op_e               op,
    output logic                  csr_we,
    output logic                  rd_we,
    output logic [REG_ADDR_W-1:0] rd_addr
);

    csr_op_e         op_d;
    logic [XLEN-1:0] operand_d;
    logic            imm_form;
    logic            src_nz;
    logic            csr_we_d;
    logic            rd_we_d;

    // Store read starts in the accept cycle, upper CSR bits alias
    assign rd_en       = accept;
    assign rd_addr_req = instr.r.csr[CSR_ADDR_W-1:0];

    always_comb begin
        case (instr.r.funct3)
            F3_CSRRW, F3_CSRRWI: op_d = OP_WRITE;
            F3_CSRRS, F3_CSRRSI: op_d = OP_SET;
            F3_CSRRC, F3_CSRRCI: op_d = OP_CLEAR;
            default:             op_d = OP_NONE;
        endcase
    end

    // funct3[2] selects the immediate view of the word
    assign imm_form  = instr.r.funct3[2];
    assign operand_d = imm_form ? {{(XLEN-ZIMM_W){1'b0}}, instr.i.zimm} : rs1_val;

    // Same bit slot for rs1 and zimm, nonzero either way enables set/clear
    assign src_nz = (instr.r.rs1 != '0);

    always_comb begin
        case (op_d)
            OP_WRITE:          csr_we_d = 1'b1;
            OP_SET, OP_CLEAR:  csr_we_d = src_nz;
            default:           csr_we_d = 1'b0;
        endcase
    end

    assign rd_we_d = (instr.r.rd != '0) && (op_d != OP_NONE);

    // Control fields of the accepted instruction
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            op     <= OP_NONE;
            csr_we <= 1'b0;
            rd_we  <= 1'b0;
        end else if (srst) begin
            op     <= OP_NONE;
            csr_we <= 1'b0;
            rd_we  <= 1'b0;
        end else if (accept) begin
            op     <= op_d;
            csr_we <= csr_we_d;
            rd_we  <= rd_we_d;
        end
    end

    // Payload, held until the next transfer
    always_ff @(posedge aclk) begin
        if (accept) begin
            operand  <= operand_d;
            rd_addr  <= instr.r.rd;
            csr_addr <= instr.r.csr[CSR_ADDR_W-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/csr_exec.sv ====
/*
 * CSR execution control
 * Handshake FSM that computes the new CSR value and drives CSR and rd writes
 */

`timescale 1ns/1ps
`default_nettype none

module csr_exec
    import csr_pkg::*;
(
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  srst,
    input  logic                  valid,
    input  logic [XLEN-1:0]       old_val,
    input  logic [XLEN-1:0]       operand,
    input  csr_op_e               op,
    input  logic                  csr_we,
    input  logic                  rd_we,
    input  logic [CSR_ADDR_W-1:0] csr_addr,
    output logic                  ready,
    output logic                  accept,
    output logic                  wr_en,
    output logic [CSR_ADDR_W-1:0] wr_addr,
    output logic [XLEN-1:0]       wr_data,
    output logic                  rd_wr,
    output logic [XLEN-1:0]       rd_val
);

    typedef enum logic [1:0] {
        IDLE,
        COMPUTE,
        STORE
    } state_e;

    state_e          state;
    logic [XLEN-1:0] new_val;

    // Only the idle state takes a new instruction
    assign ready  = (state == IDLE);
    assign accept = valid && ready;

    // Merge the old CSR value with the operand
    always_comb begin
        case (op)
            OP_WRITE: new_val = operand;
            OP_SET:   new_val = old_val | operand;
            OP_CLEAR: new_val = old_val & ~operand;
            default:  new_val = old_val;
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state  <= IDLE;
            rd_wr  <= 1'b0;
            rd_val <= '0;
            wr_en  <= 1'b0;
        end else if (srst) begin
            state  <= IDLE;
            rd_wr  <= 1'b0;
            rd_val <= '0;
            wr_en  <= 1'b0;
        end else begin
            // Both writes are single-cycle pulses
            rd_wr <= 1'b0;
            wr_en <= 1'b0;

            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= COMPUTE;
                    end
                end

                // Old value and decoded fields are valid here
                COMPUTE: begin
                    rd_wr  <= rd_we;
                    rd_val <= old_val;
                    wr_en  <= csr_we;
                    state  <= STORE;
                end

                // Write lands at the end of this cycle, so the
                // next read sees the updated entry
                STORE: begin
                    state <= IDLE;
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Write payload, qualified by wr_en
    always_ff @(posedge aclk) begin
        if (state == COMPUTE) begin
            wr_addr <= csr_addr;
            wr_data <= new_val;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/csr_pkg.sv ====
/*
 * CSR unit package
 * Widths, funct3 codes, operation kinds and the Zicsr instruction layout
 */

`default_nettype none

package csr_pkg;

    // Data and address widths
    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 8;
    localparam int CSR_DEPTH  = 1 << CSR_ADDR_W;
    localparam int REG_ADDR_W = 5;
    localparam int ZIMM_W     = 5;

    // Instruction field widths
    localparam int CSR_W      = 12;
    localparam int FUNCT3_W   = 3;
    localparam int OPCODE_W   = 7;

    // Zicsr funct3 codes
    localparam logic [FUNCT3_W-1:0] F3_CSRRW  = 3'd1;
    localparam logic [FUNCT3_W-1:0] F3_CSRRS  = 3'd2;
    localparam logic [FUNCT3_W-1:0] F3_CSRRC  = 3'd3;
    localparam logic [FUNCT3_W-1:0] F3_CSRRWI = 3'd5;
    localparam logic [FUNCT3_W-1:0] F3_CSRRSI = 3'd6;
    localparam logic [FUNCT3_W-1:0] F3_CSRRCI = 3'd7;

    // Kind of update applied to the CSR
    typedef enum logic [1:0] {
        OP_NONE,
        OP_WRITE,
        OP_SET,
        OP_CLEAR
    } csr_op_e;

    // Register form, source operand comes from rs1
    typedef struct packed {
        logic [CSR_W-1:0]      csr;
        logic [REG_ADDR_W-1:0] rs1;
        logic [FUNCT3_W-1:0]   funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [OPCODE_W-1:0]   opcode;
    } csr_reg_t;

    // Immediate form, the rs1 slot carries a 5-bit unsigned immediate
    typedef struct packed {
        logic [CSR_W-1:0]      csr;
        logic [ZIMM_W-1:0]     zimm;
        logic [FUNCT3_W-1:0]   funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [OPCODE_W-1:0]   opcode;
    } csr_imm_t;

    // One instruction word, two decodings picked by funct3[2]
    typedef union packed {
        csr_reg_t r;
        csr_imm_t i;
    } csr_instr_u;

endpackage

`default_nettype wire

// ==== verilog/csr_store.sv ====
/*
 * CSR storage
 * Plain memory with a registered read port and one write port
 */

`timescale 1ns/1ps
`default_nettype none

module csr_store
    import csr_pkg::*;
(
    input  logic                  aclk,
    input  logic                  rd_en,
    input  logic [CSR_ADDR_W-1:0] rd_addr,
    input  logic                  wr_en,
    input  logic [CSR_ADDR_W-1:0] wr_addr,
    input  logic [XLEN-1:0]       wr_data,
    output logic [XLEN-1:0]       rd_data
);

    logic [XLEN-1:0] mem [CSR_DEPTH];

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Old value shows up one cycle after the request
    always_ff @(posedge aclk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/csr_unit.sv ====
/*
 * CSR execution unit top level
 * Decode and store work on the accepted instruction, exec merges their results
 */

`timescale 1ns/1ps
`default_nettype none

module csr_unit
    import csr_pkg::*;
(
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  srst,
    input  logic                  valid,
    input  csr_instr_u            instr,
    input  logic [XLEN-1:0]       rs1_val,
    output logic                  ready,
    output logic                  rd_wr,
    output logic [REG_ADDR_W-1:0] rd_addr,
    output logic [XLEN-1:0]       rd_val
);

    logic                  accept;
    logic                  rd_en;
    logic [CSR_ADDR_W-1:0] rd_addr_req;
    logic [CSR_ADDR_W-1:0] csr_addr;
    logic [XLEN-1:0]       operand;
    csr_op_e               op;
    logic                  csr_we;
    logic                  rd_we;
    logic [XLEN-1:0]       old_val;
    logic                  wr_en;
    logic [CSR_ADDR_W-1:0] wr_addr;
    logic [XLEN-1:0]       wr_data;

    csr_decode decode_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .srst        (srst),
        .accept      (accept),
        .instr       (instr),
        .rs1_val     (rs1_val),
        .rd_en       (rd_en),
        .rd_addr_req (rd_addr_req),
        .csr_addr    (csr_addr),
        .operand     (operand),
        .op          (op),
        .csr_we      (csr_we),
        .rd_we       (rd_we),
        .rd_addr     (rd_addr)
    );

    csr_store store_i (
        .aclk    (aclk),
        .rd_en   (rd_en),
        .rd_addr (rd_addr_req),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_data (old_val)
    );

    csr_exec exec_i (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .srst     (srst),
        .valid    (valid),
        .old_val  (old_val),
        .operand  (operand),
        .op       (op),
        .csr_we   (csr_we),
        .rd_we    (rd_we),
        .csr_addr (csr_addr),
        .ready    (ready),
        .accept   (accept),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_wr    (rd_wr),
        .rd_val   (rd_val)
    );

endmodule

`default_nettype wire
